/* Bender.yml */
package:
  name: cog_centroid

sources:
  - files:
      - design/cog_pkg.sv
      - design/cog_frame_sequencer.sv
      - design/cog_moment_accumulator.sv
      - design/cog_divider.sv
      - design/cog_centroid.sv
  - target: test
    files:
      - verification/cog_tb_clock.sv
      - verification/cog_centroid_assert.sv
      - verification/cog_tb.sv

/* cog_centroid.f */
design/cog_pkg.sv
design/cog_frame_sequencer.sv
design/cog_moment_accumulator.sv
design/cog_divider.sv
design/cog_centroid.sv
verification/cog_tb_clock.sv
verification/cog_centroid_assert.sv
verification/cog_tb.sv

/* design/cog_centroid.sv */
//----------------------------------------
// Centre of gravity of a 16x16 binary frame
// Row memory answers row_rd one cycle later
// Results hold until the next frame
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cog_centroid (
    input  wire logic               CCLK,
    input  wire logic               RST_N,
    input  wire logic               vsync,
    input  wire cog_pkg::rows_t     v_size,
    input  wire cog_pkg::row_t      row_data,
    input  wire logic               row_valid,
    output logic                    row_rd,
    output cog_pkg::row_addr_t      row_addr,
    output cog_pkg::sum_s_t         sum_s,
    output cog_pkg::sum_m_t         sum_sx,
    output cog_pkg::sum_m_t         sum_sy,
    output logic                    sums_valid,
    output cog_pkg::sum_m_t         cog_x,
    output cog_pkg::sum_m_t         cog_y,
    output logic                    cog_valid
);

    logic frame_clear;
    logic reduce_start;

    cog_frame_sequencer i_sequencer (
        .CCLK         (CCLK),
        .RST_N        (RST_N),
        .vsync        (vsync),
        .v_size       (v_size),
        .cog_valid    (cog_valid),
        .row_rd       (row_rd),
        .row_addr     (row_addr),
        .frame_clear  (frame_clear),
        .reduce_start (reduce_start)
    );

    cog_moment_accumulator i_accumulator (
        .CCLK         (CCLK),
        .RST_N        (RST_N),
        .frame_clear  (frame_clear),
        .row_valid    (row_valid),
        .row_data     (row_data),
        .reduce_start (reduce_start),
        .sum_s        (sum_s),
        .sum_sy       (sum_sy),
        .sum_sx       (sum_sx),
        .sums_valid   (sums_valid)
    );

    //----------------------------------------
    // Both dividers start together and finish together
    //----------------------------------------
    cog_divider i_div_x (
        .CCLK     (CCLK),
        .RST_N    (RST_N),
        .start    (sums_valid),
        .dividend (sum_sx),
        .divisor  (sum_s),
        .quotient (cog_x),
        .done     (cog_valid)
    );

    cog_divider i_div_y (
        .CCLK     (CCLK),
        .RST_N    (RST_N),
        .start    (sums_valid),
        .dividend (sum_sy),
        .divisor  (sum_s),
        .quotient (cog_y),
        .done     ()
    );

endmodule

`default_nettype wire

/* design/cog_divider.sv */
//----------------------------------------
// Serial restoring divider, integer quotient
// done follows start by DIV_CYCLES cycles
// Divisor 0 gives an all-ones quotient
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cog_divider (
    input  wire logic               CCLK,
    input  wire logic               RST_N,
    input  wire logic               start,
    input  wire cog_pkg::sum_m_t    dividend,
    input  wire cog_pkg::sum_s_t    divisor,
    output cog_pkg::sum_m_t         quotient,
    output logic                    done
);
    import cog_pkg::*;

    typedef logic [$clog2(SUM_M_W)-1:0] step_t;

    logic             busy;
    step_t            step;
    sum_m_t           dvd;
    sum_s_t           dvs;
    sum_s_t           rem;
    logic [SUM_S_W:0] trial;
    logic [SUM_S_W:0] diff;
    logic             q_bit;
    sum_s_t           rem_nxt;

    // One subtract-and-restore step
    always_comb begin
        trial   = {rem, dvd[SUM_M_W-1]};
        diff    = trial - {1'b0, dvs};
        q_bit   = (trial >= {1'b0, dvs});
        rem_nxt = q_bit ? diff[SUM_S_W-1:0] : trial[SUM_S_W-1:0];
    end

    // Quotient bits shift in behind the dividend
    always_ff @(posedge CCLK) begin
        if (start) begin
            dvd <= dividend;
            dvs <= divisor;
            rem <= '0;
        end else if (busy) begin
            dvd <= {dvd[SUM_M_W-2:0], q_bit};
            rem <= rem_nxt;
        end
    end

    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            busy     <= 1'b0;
            step     <= '0;
            quotient <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == step_t'(SUM_M_W - 1)) begin
                    busy     <= 1'b0;
                    done     <= 1'b1;
                    quotient <= {dvd[SUM_M_W-2:0], q_bit};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/cog_frame_sequencer.sv */
//----------------------------------------
// Frame FSM, started by a vsync rise in IDLE
// First row_rd comes 2 cycles after vsync rises
// REDUCE length is fixed to the column reduction
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cog_frame_sequencer (
    input  wire logic               CCLK,
    input  wire logic               RST_N,
    input  wire logic               vsync,
    input  wire cog_pkg::rows_t     v_size,
    input  wire logic               cog_valid,
    output logic                    row_rd,
    output cog_pkg::row_addr_t      row_addr,
    output logic                    frame_clear,
    output logic                    reduce_start
);
    import cog_pkg::*;

    typedef logic [COL_IDX_W:0] red_cnt_t;

    seq_state_t state;
    logic       vsync_q;
    logic       vsync_qq;
    logic       vsync_rise;
    logic       last_row;
    red_cnt_t   red_cnt;

    assign vsync_rise = vsync_q & ~vsync_qq;
    assign last_row   = (rows_t'(row_addr) + rows_t'(1)) == v_size;
    assign row_rd     = (state == READ);

    // Vsync sample and edge register
    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            vsync_q  <= 1'b0;
            vsync_qq <= 1'b0;
        end else begin
            vsync_q  <= vsync;
            vsync_qq <= vsync_q;
        end
    end

    //----------------------------------------
    // Frame FSM
    //----------------------------------------
    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            state        <= IDLE;
            row_addr     <= '0;
            red_cnt      <= '0;
            frame_clear  <= 1'b0;
            reduce_start <= 1'b0;
        end else begin
            frame_clear  <= 1'b0;
            reduce_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (vsync_rise) begin
                        state       <= READ;
                        row_addr    <= '0;
                        frame_clear <= 1'b1;
                    end
                end
                READ: begin
                    if (last_row) begin
                        state        <= REDUCE;
                        row_addr     <= '0;
                        red_cnt      <= '0;
                        reduce_start <= 1'b1;
                    end else begin
                        row_addr <= row_addr + 1'b1;
                    end
                end
                REDUCE: begin
                    // Accumulator needs COLS + 1 cycles after the last row
                    if (red_cnt == red_cnt_t'(COLS)) begin
                        state <= DIVIDE;
                    end else begin
                        red_cnt <= red_cnt + 1'b1;
                    end
                end
                DIVIDE: begin
                    if (cog_valid) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/cog_moment_accumulator.sv */
//----------------------------------------
// Per-frame sums S, SY and SX
// Rows are indexed in arrival order after frame_clear
// Sums hold until the next frame_clear
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cog_moment_accumulator (
    input  wire logic               CCLK,
    input  wire logic               RST_N,
    input  wire logic               frame_clear,
    input  wire logic               row_valid,
    input  wire cog_pkg::row_t      row_data,
    input  wire logic               reduce_start,
    output cog_pkg::sum_s_t         sum_s,
    output cog_pkg::sum_m_t         sum_sy,
    output cog_pkg::sum_m_t         sum_sx,
    output logic                    sums_valid
);
    import cog_pkg::*;

    typedef logic [COL_IDX_W-1:0] col_idx_t;

    sum_s_t    row_cnt;
    sum_m_t    row_moment;
    sum_m_t    col_moment;
    row_addr_t row_idx;
    rows_t     col_cnt [COLS];
    logic      reducing;
    col_idx_t  col_idx;

    // Popcount of the incoming row
    always_comb begin
        row_cnt = '0;
        for (int c = 0; c < COLS; c++) begin
            row_cnt = row_cnt + sum_s_t'(row_data[c]);
        end
    end

    assign row_moment = sum_m_t'(row_idx) * sum_m_t'(row_cnt);
    assign col_moment = sum_m_t'(col_idx) * sum_m_t'(col_cnt[col_idx]);

    // One counter per column, cleared at frame start
    always_ff @(posedge CCLK) begin
        for (int c = 0; c < COLS; c++) begin
            if (frame_clear) begin
                col_cnt[c] <= '0;
            end else if (row_valid && row_data[c]) begin
                col_cnt[c] <= col_cnt[c] + 1'b1;
            end
        end
    end

    //----------------------------------------
    // Row sums and serial SX reduction
    //----------------------------------------
    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            row_idx    <= '0;
            sum_s      <= '0;
            sum_sy     <= '0;
            sum_sx     <= '0;
            reducing   <= 1'b0;
            col_idx    <= '0;
            sums_valid <= 1'b0;
        end else begin
            sums_valid <= 1'b0;
            if (frame_clear) begin
                row_idx <= '0;
                sum_s   <= '0;
                sum_sy  <= '0;
                sum_sx  <= '0;
            end else if (row_valid) begin
                row_idx <= row_idx + 1'b1;
                sum_s   <= sum_s + row_cnt;
                sum_sy  <= sum_sy + row_moment;
            end
            // Last row lands together with reduce_start
            if (reduce_start) begin
                reducing <= 1'b1;
                col_idx  <= '0;
            end else if (reducing) begin
                sum_sx  <= sum_sx + col_moment;
                col_idx <= col_idx + 1'b1;
                if (col_idx == col_idx_t'(COLS - 1)) begin
                    reducing   <= 1'b0;
                    sums_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/cog_pkg.sv */
//----------------------------------------
// Frame geometry and widths of the COG core
// Sums are sized for a fully set 16x16 frame
// v_size must lie in 1..MAX_ROWS
//----------------------------------------
`default_nettype none

package cog_pkg;

    // Frame geometry
    localparam int COLS       = 16;
    localparam int MAX_ROWS   = 16;
    localparam int ROW_ADDR_W = $clog2(MAX_ROWS);
    localparam int ROWS_W     = $clog2(MAX_ROWS) + 1;
    localparam int COL_IDX_W  = $clog2(COLS);

    // Sum and quotient widths
    localparam int SUM_S_W    = 9;
    localparam int SUM_M_W    = 12;

    // Operand latch plus one step per quotient bit
    localparam int DIV_CYCLES = SUM_M_W + 1;

    typedef logic [COLS-1:0]       row_t;
    typedef logic [ROW_ADDR_W-1:0] row_addr_t;
    typedef logic [ROWS_W-1:0]     rows_t;
    typedef logic [SUM_S_W-1:0]    sum_s_t;
    typedef logic [SUM_M_W-1:0]    sum_m_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        REDUCE,
        DIVIDE
    } seq_state_t;

endpackage

`default_nettype wire

/* verification/cog_centroid_assert.sv */
//----------------------------------------
// Pulse, latency and row address rules
// Bound to every cog_centroid instance
// assert_fails counts failed assertions
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cog_centroid_assert (
    input  wire logic                CCLK,
    input  wire logic                RST_N,
    input  wire logic                vsync,
    input  wire cog_pkg::rows_t      v_size,
    input  wire logic                row_rd,
    input  wire cog_pkg::row_addr_t  row_addr,
    input  wire logic                sums_valid,
    input  wire logic                cog_valid
);
    import cog_pkg::*;

    int   assert_fails = 0;
    logic vsync_q;
    logic frame_done;

    // High from sums_valid until the next vsync rise
    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            vsync_q    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            vsync_q <= vsync;
            if (sums_valid) begin
                frame_done <= 1'b1;
            end else if (vsync && !vsync_q) begin
                frame_done <= 1'b0;
            end
        end
    end

    a_sums_pulse: assert property (
        @(posedge CCLK) disable iff (!RST_N) sums_valid |=> !sums_valid
    ) else begin
        $error("sums_valid high for more than one cycle");
        assert_fails++;
    end

    a_cog_pulse: assert property (
        @(posedge CCLK) disable iff (!RST_N) cog_valid |=> !cog_valid
    ) else begin
        $error("cog_valid high for more than one cycle");
        assert_fails++;
    end

    // Divider latency is fixed
    a_div_latency: assert property (
        @(posedge CCLK) disable iff (!RST_N)
        sums_valid |=> !cog_valid [*(DIV_CYCLES - 1)] ##1 cog_valid
    ) else begin
        $error("cog_valid not exactly DIV_CYCLES after sums_valid");
        assert_fails++;
    end

    a_addr_range: assert property (
        @(posedge CCLK) disable iff (!RST_N) row_rd |-> (rows_t'(row_addr) < v_size)
    ) else begin
        $error("row_addr not below v_size during row_rd");
        assert_fails++;
    end

    a_no_late_read: assert property (
        @(posedge CCLK) disable iff (!RST_N) frame_done |-> !row_rd
    ) else begin
        $error("row_rd after sums_valid without a new vsync rise");
        assert_fails++;
    end

endmodule

bind cog_centroid cog_centroid_assert i_assert (
    .CCLK       (CCLK),
    .RST_N      (RST_N),
    .vsync      (vsync),
    .v_size     (v_size),
    .row_rd     (row_rd),
    .row_addr   (row_addr),
    .sums_valid (sums_valid),
    .cog_valid  (cog_valid)
);

`default_nettype wire

/* verification/cog_tb.sv */
//----------------------------------------
// 40 frames from seed 54 against a software COG model
// First 4 frames are fixed corner cases
// Stops at the first error
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cog_tb;
    import cog_pkg::*;

    localparam int FRAMES       = 40;
    localparam int FRAME_CYCLES = MAX_ROWS + COLS + DIV_CYCLES + 20;
    localparam int CLK_NS       = 8;
    localparam int WATCHDOG_NS  = FRAMES * FRAME_CYCLES * CLK_NS * 2;

    logic      CCLK;
    logic      RST_N;
    logic      vsync;
    rows_t     v_size;
    row_t      row_data;
    logic      row_valid;
    logic      row_rd;
    row_addr_t row_addr;
    sum_s_t    sum_s;
    sum_m_t    sum_sx;
    sum_m_t    sum_sy;
    logic      sums_valid;
    sum_m_t    cog_x;
    sum_m_t    cog_y;
    logic      cog_valid;

    int        seed = 54;
    row_t      frame_mem [MAX_ROWS];
    row_addr_t read_log [$];

    cog_tb_clock i_clock (
        .CCLK  (CCLK),
        .RST_N (RST_N)
    );

    cog_centroid i_cog_centroid (
        .CCLK       (CCLK),
        .RST_N      (RST_N),
        .vsync      (vsync),
        .v_size     (v_size),
        .row_data   (row_data),
        .row_valid  (row_valid),
        .row_rd     (row_rd),
        .row_addr   (row_addr),
        .sum_s      (sum_s),
        .sum_sx     (sum_sx),
        .sum_sy     (sum_sy),
        .sums_valid (sums_valid),
        .cog_x      (cog_x),
        .cog_y      (cog_y),
        .cog_valid  (cog_valid)
    );

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    //----------------------------------------
    // Compare tasks
    //----------------------------------------
    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_sum_s(input string name, input sum_s_t got, input sum_s_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_moment(input string name, input sum_m_t got, input sum_m_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_rows(input string name, input rows_t got, input rows_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_row_addr(input string name, input row_addr_t got,
                                  input row_addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    //----------------------------------------
    // Reference model
    //----------------------------------------
    // level in 0..4 sets each pixel with probability level/4
    function automatic row_t random_row(input int level);
        row_t row;
        row = '0;
        for (int c = 0; c < COLS; c++) begin
            row[c] = (($random(seed) & 3) < level);
        end
        return row;
    endfunction

    task automatic compute_model(input rows_t rows, output sum_s_t s,
                                 output sum_m_t sx, output sum_m_t sy);
        int acc_s;
        int acc_sx;
        int acc_sy;
        acc_s  = 0;
        acc_sx = 0;
        acc_sy = 0;
        for (int r = 0; r < int'(rows); r++) begin
            for (int c = 0; c < COLS; c++) begin
                if (frame_mem[r][c]) begin
                    acc_s  += 1;
                    acc_sx += c;
                    acc_sy += r;
                end
            end
        end
        // Full sums must fit the DUT outputs
        if (acc_s >= (1 << SUM_S_W) || acc_sx >= (1 << SUM_M_W) ||
            acc_sy >= (1 << SUM_M_W)) begin
            stop_on_error("the frame sums do not fit the DUT sum widths");
        end
        s  = sum_s_t'(acc_s);
        sx = sum_m_t'(acc_sx);
        sy = sum_m_t'(acc_sy);
    endtask

    // Empty frame gives an all-ones quotient
    function automatic sum_m_t floor_div(input sum_m_t num, input sum_s_t den);
        if (den == '0) begin
            return '1;
        end
        return sum_m_t'(int'(num) / int'(den));
    endfunction

    // Row memory with one cycle read latency
    always @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            row_valid <= 1'b0;
            row_data  <= '0;
        end else begin
            row_valid <= row_rd;
            if (row_rd) begin
                row_data <= frame_mem[row_addr];
            end
        end
    end

    always @(negedge CCLK) begin
        if (RST_N && row_rd) begin
            read_log.push_back(row_addr);
        end
    end

    always @(negedge CCLK) begin
        if (i_cog_centroid.i_assert.assert_fails != 0) begin
            stop_on_error("a bound assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error($sformatf("the run timed out after %0d ns", WATCHDOG_NS));
    end

    task automatic wait_for_result(input bit final_stage);
        int cycles;
        cycles = 0;
        do begin
            @(negedge CCLK);
            cycles++;
            if (cycles > FRAME_CYCLES) begin
                stop_on_error(final_stage ? "cog_valid never arrived"
                                          : "sums_valid never arrived");
            end
        end while (final_stage ? !cog_valid : !sums_valid);
    endtask

    task automatic check_reads(input rows_t rows);
        if (read_log.size() > MAX_ROWS) begin
            stop_on_error("more row reads than a frame can hold");
        end
        check_rows("row read count", rows_t'(read_log.size()), rows);
        foreach (read_log[i]) begin
            check_row_addr("row_addr", read_log[i], row_addr_t'(i));
        end
    endtask

    task automatic run_frame(input rows_t rows, input int level, input bit extra_vsync);
        sum_s_t exp_s;
        sum_m_t exp_sx;
        sum_m_t exp_sy;
        for (int r = 0; r < MAX_ROWS; r++) begin
            frame_mem[r] = random_row(level);
        end
        compute_model(rows, exp_s, exp_sx, exp_sy);
        read_log.delete();
        @(posedge CCLK);
        v_size <= rows;
        vsync  <= 1'b1;
        repeat (2) @(posedge CCLK);
        vsync <= 1'b0;
        // Second rise while the frame runs
        if (extra_vsync) begin
            repeat (2) @(posedge CCLK);
            vsync <= 1'b1;
            repeat (2) @(posedge CCLK);
            vsync <= 1'b0;
        end
        wait_for_result(1'b0);
        check_sum_s("sum_s", sum_s, exp_s);
        check_moment("sum_sx", sum_sx, exp_sx);
        check_moment("sum_sy", sum_sy, exp_sy);
        wait_for_result(1'b1);
        check_moment("cog_x", cog_x, floor_div(exp_sx, exp_s));
        check_moment("cog_y", cog_y, floor_div(exp_sy, exp_s));
        check_reads(rows);
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial begin
        rows_t rows;
        int    level;
        bit    extra;
        vsync     = 1'b0;
        v_size    = rows_t'(1);
        row_data  = '0;
        row_valid = 1'b0;
        @(posedge RST_N);
        repeat (3) @(negedge CCLK);
        check_flag("row_rd", row_rd, 1'b0);
        check_flag("sums_valid", sums_valid, 1'b0);
        check_flag("cog_valid", cog_valid, 1'b0);
        check_sum_s("sum_s", sum_s, '0);
        check_moment("sum_sx", sum_sx, '0);
        check_moment("sum_sy", sum_sy, '0);
        check_moment("cog_x", cog_x, '0);
        check_moment("cog_y", cog_y, '0);

        // Full frames, single row, empty frame
        run_frame(rows_t'(MAX_ROWS), 4, 1'b0);
        run_frame(rows_t'(1), 4, 1'b0);
        run_frame(rows_t'(MAX_ROWS), 0, 1'b0);
        run_frame(rows_t'(MAX_ROWS), 4, 1'b1);
        for (int f = 4; f < FRAMES; f++) begin
            rows  = rows_t'(($random(seed) & 15) + 1);
            level = $unsigned($random(seed)) % 5;
            extra = (($random(seed) & 3) == 0);
            run_frame(rows, level, extra);
        end

        repeat (4) @(negedge CCLK);
        if (i_cog_centroid.i_assert.assert_fails == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_on_error("bound assertions reported failures");
        end
    end

endmodule

`default_nettype wire

/* verification/cog_tb_clock.sv */
//----------------------------------------
// 8 ns clock, RST_N low for 10 cycles
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cog_tb_clock (
    output logic CCLK,
    output logic RST_N
);
    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES   = 10;

    initial begin
        CCLK = 1'b0;
        forever #(HALF_PERIOD_NS) CCLK = ~CCLK;
    end

    initial begin
        RST_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge CCLK);
        RST_N <= 1'b1;
    end

endmodule

`default_nettype wire
